/* dv/lb_tb_table.svh */
// Testbench table: register checks, traffic, drops, busy slots and slot counts
`ifndef LB_TB_TABLE_SVH
`define LB_TB_TABLE_SVH

// Columns: operation, register address, interface or core index, data, expected readback
// Slot rows carry {busy[15:8], valids[7:0]} in the data column
task automatic build_table();
  //////////////////////////////////////////////////
  // Reset values, unknown address, flush pulse
  add_row(OP_RD, `LB_REG_ENABLED, 4'd0, 32'h0, 32'h0);
  add_row(OP_RD, `LB_REG_INCOME, 4'd0, 32'h0, 32'h0);
  add_row(OP_RD, 5'd7, 4'd0, 32'h0, `LB_RD_DEFAULT);
  add_row(OP_WR, `LB_REG_FLUSH, 4'd0, 32'hA5, 32'h0);
  //////////////////////////////////////////////////
  // Income mask filtered by the enabled mask
  add_row(OP_WR, `LB_REG_INCOME, 4'd0, 32'hFF, 32'h0);
  add_row(OP_RD, `LB_REG_INCOME, 4'd0, 32'h0, 32'h0);
  add_row(OP_WR, `LB_REG_ENABLED, 4'd0, 32'h3C, 32'h0);
  add_row(OP_WR, `LB_REG_INCOME, 4'd0, 32'hFF, 32'h0);
  add_row(OP_RD, `LB_REG_INCOME, 4'd0, 32'h0, 32'h3C);
  // Shrinking the enabled mask clears income bits
  add_row(OP_WR, `LB_REG_ENABLED, 4'd0, 32'h0C, 32'h0);
  add_row(OP_RD, `LB_REG_INCOME, 4'd0, 32'h0, 32'h0C);
  add_row(OP_RD, `LB_REG_ENABLED, 4'd0, 32'h0, 32'h0C);
  //////////////////////////////////////////////////
  // All cores open, random traffic on every interface
  add_row(OP_WR, `LB_REG_ENABLED, 4'd0, 32'hFF, 32'h0);
  add_row(OP_WR, `LB_REG_INCOME, 4'd0, 32'hFF, 32'h0);
  add_row(OP_SLOTS, 5'd0, 4'd0, 32'h00FF, 32'h0);
  for (int n = 0; n < 9; n++) begin
    add_row(OP_PUSH_RAND, 5'd0, 4'(n % 3), 32'h0, 32'h0);
  end
  add_row(OP_IDLE, 5'd0, 4'd0, 32'h0, 32'h0);
  //////////////////////////////////////////////////
  // Core 7 closed, hash waits until the fill level hits the limit
  add_row(OP_WR, `LB_REG_LIMIT, 4'd0, 32'h64, 32'h0);
  add_row(OP_WR, `LB_REG_INCOME, 4'd0, 32'h7F, 32'h0);
  add_row(OP_PUSH, 5'd0, 4'd1, 32'hA5A1C0DE, 32'h0);
  add_row(OP_RD, `LB_REG_DROPS, 4'd1, 32'h0, 32'h0);
  add_row(OP_RD, `LB_REG_DROPS, 4'd1, 32'h0, 32'h0);
  add_row(OP_LINES, 5'd0, 4'd1, 32'h64, 32'h0);
  add_row(OP_IDLE, 5'd0, 4'd0, 32'h0, 32'h0);
  add_row(OP_RD, `LB_REG_DROPS, 4'd1, 32'h0, 32'h1);
  //////////////////////////////////////////////////
  // Busy core 3 holds two hashes back, release keeps order
  add_row(OP_SLOTS, 5'd0, 4'd0, 32'h08FF, 32'h0);
  add_row(OP_PUSH, 5'd0, 4'd0, 32'h1234C111, 32'h0);
  add_row(OP_PUSH, 5'd0, 4'd0, 32'h9870C222, 32'h0);
  add_row(OP_RD, `LB_REG_ENABLED, 4'd0, 32'h0, 32'hFF);
  add_row(OP_RD, `LB_REG_INCOME, 4'd0, 32'h0, 32'h7F);
  add_row(OP_SLOTS, 5'd0, 4'd0, 32'h00FF, 32'h0);
  add_row(OP_IDLE, 5'd0, 4'd0, 32'h0, 32'h0);
  // Slot counts follow 9 * core + 4
  add_row(OP_RD, `LB_REG_SLOTS, 4'd5, 32'h0, 32'h31);
  add_row(OP_RD, `LB_REG_SLOTS, 4'd2, 32'h0, 32'h16);
endtask

`endif

/* dv/lb_tb.sv */
// Load balancer testbench with table driven stimulus, result model and checks
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_tb;

  typedef enum logic [2:0] {
    OP_WR, OP_RD, OP_SLOTS, OP_LINES, OP_PUSH, OP_PUSH_RAND, OP_IDLE
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [4:0]  addr;
    logic [3:0]  idx;
    logic [31:0] data;
    logic [31:0] exp;
  } row_t;

  logic               clk;
  logic               rst;
  lb_pkg::if_mask_t   hash_valid;
  lb_pkg::hash_t      hash_in [`LB_IF_COUNT];
  lb_pkg::lines_t     line_count [`LB_IF_COUNT];
  lb_pkg::host_cmd_t  host_cmd;
  logic               host_cmd_for_ints;
  lb_pkg::word_t      host_cmd_wr_data;
  logic               host_cmd_wr_en;
  lb_pkg::word_t      host_cmd_rd_data;
  lb_pkg::core_mask_t enabled_cores;
  lb_pkg::core_mask_t slots_flush;
  lb_pkg::slot_cnt_t  slot_counts [`LB_CORE_COUNT];
  lb_pkg::core_mask_t slot_valids;
  lb_pkg::core_mask_t slots_busy;
  lb_pkg::core_id_t   selected_core;
  logic               desc_pop;
  lb_pkg::desc_t      desc_data;
  lb_pkg::if_mask_t   result_valid;
  lb_pkg::hash_t      result_hash;
  lb_pkg::desc_t      result_desc;
  logic               result_drop;

  row_t        rows [$];
  // Pending results as {interface, hash} in push order
  logic [33:0] expect_q [$];
  logic [7:0]  model_enabled;
  logic [7:0]  model_income;
  logic [12:0] model_limit;
  logic [5:0]  tag_count;
  logic [5:0]  model_tag;
  int          errors;
  int          checks;
  bit          table_ready;

  lb_hash_dropping_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Descriptor source returns the core number and a running pop count as tag
  assign desc_data = {selected_core, tag_count};

  always @(posedge clk) begin
    if (rst) begin
      tag_count <= '0;
    end else if (desc_pop) begin
      tag_count <= tag_count + 6'd1;
    end
  end

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
    end
  endtask

  function automatic void add_row(op_t op, logic [4:0] addr, logic [3:0] idx,
                                  logic [31:0] data, logic [31:0] exp);
    rows.push_back('{op, addr, idx, data, exp});
  endfunction

`include "lb_tb_table.svh"

  //////////////////////////////////////////////////
  // Host port and traffic drivers
  task automatic write_reg(input logic [4:0] addr, input logic [3:0] idx,
                           input logic [31:0] data);
    @(posedge clk);
    host_cmd          <= lb_pkg::host_cmd_t'({idx, addr[3:0]});
    host_cmd_for_ints <= addr[4];
    host_cmd_wr_data  <= data;
    host_cmd_wr_en    <= 1'b1;
    @(posedge clk);
    host_cmd_wr_en <= 1'b0;
    // Model follows the register once the write has landed
    if (addr == `LB_REG_ENABLED) begin
      model_income  = model_income & data[7:0];
      model_enabled = data[7:0];
    end else if (addr == `LB_REG_INCOME) begin
      model_income = data[7:0] & model_enabled;
    end else if (addr == `LB_REG_LIMIT) begin
      model_limit = data[12:0];
    end
    if (addr == `LB_REG_FLUSH) begin
      @(negedge clk);
      check(slots_flush == data[7:0], "no slots_flush pulse after a flush write");
      @(negedge clk);
      check(slots_flush == '0, "slots_flush stayed high for more than one cycle");
    end
  endtask

  // Readback lands one cycle after the command
  task automatic read_reg(input logic [4:0] addr, input logic [3:0] idx,
                          input logic [31:0] exp);
    @(posedge clk);
    host_cmd          <= lb_pkg::host_cmd_t'({idx, addr[3:0]});
    host_cmd_for_ints <= addr[4];
    @(posedge clk);
    @(negedge clk);
    check(host_cmd_rd_data == exp,
          $sformatf("read addr %0d idx %0d got %h expected %h",
                    addr, idx, host_cmd_rd_data, exp));
  endtask

  task automatic push_hash(input logic [1:0] ifn, input logic [31:0] h);
    @(posedge clk);
    hash_valid[ifn] <= 1'b1;
    hash_in[ifn]    <= h;
    expect_q.push_back({ifn, h});
    @(posedge clk);
    hash_valid <= '0;
  endtask

  // Idle once the model holds nothing, then a few quiet cycles
  task automatic wait_idle();
    while (expect_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (6) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Result model on outputs sampled mid-cycle
  task automatic check_outputs();
    int          k;
    int          pos;
    logic [31:0] h;
    logic [2:0]  core;
    bit          avail;
    k   = -1;
    pos = -1;
    for (int i = 0; i < `LB_IF_COUNT; i++) begin
      if (result_valid[i]) begin
        k = i;
      end
    end
    if (k < 0) begin
      check(!desc_pop, "desc_pop pulsed without a result");
    end else begin
      check($onehot(result_valid), "result_valid has more than one bit set");
      // Oldest pending hash of that interface
      foreach (expect_q[j]) begin
        if (pos < 0 && expect_q[j][33:32] == 2'(k)) begin
          pos = j;
        end
      end
      if (pos < 0) begin
        check(1'b0, $sformatf("result on interface %0d with no hash pending", k));
      end else begin
        h = expect_q[pos][31:0];
        expect_q.delete(pos);
        core  = h[16:14];
        avail = slot_valids[core] && model_income[core];
        check(result_hash == h,
              $sformatf("if %0d hash %h expected %h", k, result_hash, h));
        check(selected_core == core,
              $sformatf("selected core %0d expected %0d", selected_core, core));
        check(!slots_busy[core], "result emitted for a busy core");
        check(result_drop == !avail,
              $sformatf("if %0d drop %0b expected %0b", k, result_drop, !avail));
        check(desc_pop == avail, "desc_pop does not match the result");
        if (avail) begin
          check(result_desc == {core, model_tag},
                $sformatf("descriptor %h expected %h", result_desc, {core, model_tag}));
          model_tag = model_tag + 6'd1;
        end else begin
          check(line_count[k] >= model_limit, "drop while the fill level is below the limit");
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      check(enabled_cores == model_enabled,
            $sformatf("enabled_cores %h expected %h", enabled_cores, model_enabled));
      check_outputs();
    end
  end

  //////////////////////////////////////////////////
  // Table loop
  initial begin
    row_t r;
    void'($urandom(32'he3601ba2));
    rst               = 1'b1;
    hash_valid        = '0;
    host_cmd          = '0;
    host_cmd_for_ints = 1'b0;
    host_cmd_wr_data  = '0;
    host_cmd_wr_en    = 1'b0;
    slot_valids       = '0;
    slots_busy        = '0;
    model_enabled     = '0;
    model_income      = '0;
    model_limit       = `LB_LIMIT_RESET;
    model_tag         = '0;
    errors            = 0;
    checks            = 0;
    for (int i = 0; i < `LB_IF_COUNT; i++) begin
      hash_in[i]    = '0;
      line_count[i] = '0;
    end
    for (int i = 0; i < `LB_CORE_COUNT; i++) begin
      slot_counts[i] = 6'(9 * i + 4);
    end
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[i]) begin
      r = rows[i];
      case (r.op)
        OP_WR:        write_reg(r.addr, r.idx, r.data);
        OP_RD:        read_reg(r.addr, r.idx, r.exp);
        OP_SLOTS: begin
          @(posedge clk);
          slot_valids <= r.data[7:0];
          slots_busy  <= r.data[15:8];
        end
        OP_LINES: begin
          @(posedge clk);
          line_count[r.idx] <= r.data[12:0];
        end
        OP_PUSH:      push_hash(r.idx[1:0], r.data);
        OP_PUSH_RAND: push_hash(r.idx[1:0], $urandom);
        OP_IDLE:      wait_idle();
        default:      ;
      endcase
    end
    wait_idle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog allows 50 cycles per table row
  initial begin
    wait (table_ready);
    repeat (rows.size() * 50) @(posedge clk);
    $display("Timeout: the table did not finish within %0d cycles", rows.size() * 50);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
+incdir+dv
logic/lb_pkg.sv
logic/lb_cfg_if.sv
logic/lb_alloc_if.sv
logic/lb_hash_queue.sv
logic/lb_rr_arbiter.sv
logic/lb_desc_alloc.sv
logic/lb_host_regs.sv
logic/lb_hash_dropping_top.sv
dv/lb_tb.sv

/* logic/lb_alloc_if.sv */
// Request bus between the per-interface hash queues and the allocator
`timescale 1ns/1ps
`include "lb_defs.svh"

interface lb_alloc_if;

  // One bit per queue, high while it holds a hash
  lb_pkg::if_mask_t req;

  // Head entry of each queue
  lb_pkg::hash_t hash [`LB_IF_COUNT];

  // Registered fill level compare per interface
  lb_pkg::if_mask_t almost_full;

  // One-cycle pulse retiring the head of a queue
  lb_pkg::if_mask_t pop;

  modport queue (output req, output hash, output almost_full,
                 input pop);

  modport alloc (input req, input hash, input almost_full,
                 output pop);

endinterface

/* logic/lb_cfg_if.sv */
// Configuration and drop report bus between host registers, queues and allocator
`timescale 1ns/1ps
`include "lb_defs.svh"

interface lb_cfg_if;

  // Set by the host side
  lb_pkg::core_mask_t income_cores;
  lb_pkg::lines_t drop_limit;

  // One-cycle drop report from the allocator
  logic drop_strobe;
  lb_pkg::if_id_t drop_port;

  modport host (output income_cores, output drop_limit,
                input drop_strobe, input drop_port);

  modport alloc (input income_cores,
                 output drop_strobe, output drop_port);

  // Queues only compare their fill level
  modport queue (input drop_limit);

endinterface

/* logic/lb_defs.svh */
// Load balancer counts, widths, register map and reset values
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

// Receive interfaces and cores
`define LB_IF_COUNT      3
`define LB_IF_W          2
`define LB_CORE_COUNT    8
`define LB_CORE_W        3

// Datapath widths
`define LB_HASH_W        32
`define LB_WORD_W        32
`define LB_CMD_W         29
`define LB_SLOT_W        6
`define LB_TAG_W         6
`define LB_LINES_W       13

// Core field starts at this hash bit
`define LB_HASH_SEL_OFS  14
`define LB_QUEUE_DEPTH   16

// Register map, {for_ints, reg[3:0]}
`define LB_REG_ENABLED   5'd0
`define LB_REG_INCOME    5'd1
`define LB_REG_FLUSH     5'd2
`define LB_REG_SLOTS     5'd3
`define LB_REG_DROPS     5'd18
`define LB_REG_LIMIT     5'd19

`define LB_RD_DEFAULT    32'hFEFEFEFE
// Drop limit after reset, 7 in the top four bits
`define LB_LIMIT_RESET   13'h0E00
`endif

/* logic/lb_desc_alloc.sv */
// Registered selection, core choice from hash and pop/drop decision
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_desc_alloc (
  input  logic               clk,
  input  logic               rst,
  input  lb_pkg::if_mask_t   grant,
  input  logic               grant_valid,
  input  lb_pkg::if_id_t     grant_id,
  output lb_pkg::core_id_t   selected_core,
  output logic               desc_pop,
  input  lb_pkg::desc_t      desc_data,
  input  lb_pkg::core_mask_t slot_valids,
  input  lb_pkg::core_mask_t slots_busy,
  output lb_pkg::if_mask_t   result_valid,
  output lb_pkg::hash_t      result_hash,
  output lb_pkg::desc_t      result_desc,
  output logic               result_drop,
  output lb_pkg::if_mask_t   req_mask,
  lb_alloc_if.alloc          alloc,
  lb_cfg_if.alloc            cfg
);

  lb_pkg::if_mask_t   grant_r;
  lb_pkg::if_id_t     grant_id_r;
  logic               grant_valid_r;
  lb_pkg::core_mask_t desc_avail;

  //////////////////////////////////////////////////
  // Selection stage
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_r       <= '0;
      grant_id_r    <= '0;
      grant_valid_r <= 1'b0;
      selected_core <= '0;
    end else begin
      grant_r       <= grant;
      grant_id_r    <= grant_id;
      grant_valid_r <= grant_valid;
      // Target core is a fixed bit field of the head hash
      selected_core <= alloc.hash[grant_id][`LB_HASH_SEL_OFS +: `LB_CORE_W];
    end
  end

  // Last winner sits out one cycle while its decision is made
  assign req_mask = alloc.req & ~grant_r;

  //////////////////////////////////////////////////
  // Decision stage
  // Core must have a slot and accept interface traffic
  assign desc_avail = slot_valids & cfg.income_cores;

  always_comb begin
    desc_pop        = 1'b0;
    alloc.pop       = '0;
    result_valid    = '0;
    result_drop     = 1'b0;
    cfg.drop_strobe = 1'b0;
    // Busy core means retry later and nothing leaves
    if (grant_valid_r && !slots_busy[selected_core]) begin
      if (desc_avail[selected_core]) begin
        desc_pop     = 1'b1;
        alloc.pop    = grant_r;
        result_valid = grant_r;
      end else if (alloc.almost_full[grant_id_r]) begin
        // No slot and receive side filling up
        alloc.pop       = grant_r;
        result_valid    = grant_r;
        result_drop     = 1'b1;
        cfg.drop_strobe = 1'b1;
      end
    end
  end

  // Head still holds the granted hash until the pop
  assign result_hash   = alloc.hash[grant_id_r];
  assign result_desc   = desc_data;
  assign cfg.drop_port = grant_id_r;

endmodule

/* logic/lb_hash_dropping_top.sv */
// Load balancer top with hash queues, arbiter, allocator and host registers
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_hash_dropping_top (
  input  logic               clk,
  input  logic               rst,
  // Flow hashes from the receive interfaces
  input  lb_pkg::if_mask_t   hash_valid,
  input  lb_pkg::hash_t      hash_in [`LB_IF_COUNT],
  input  lb_pkg::lines_t     line_count [`LB_IF_COUNT],
  // Host command port
  input  lb_pkg::host_cmd_t  host_cmd,
  input  logic               host_cmd_for_ints,
  input  lb_pkg::word_t      host_cmd_wr_data,
  input  logic               host_cmd_wr_en,
  output lb_pkg::word_t      host_cmd_rd_data,
  // Core configuration and slot status
  output lb_pkg::core_mask_t enabled_cores,
  output lb_pkg::core_mask_t slots_flush,
  input  lb_pkg::slot_cnt_t  slot_counts [`LB_CORE_COUNT],
  input  lb_pkg::core_mask_t slot_valids,
  input  lb_pkg::core_mask_t slots_busy,
  // Descriptor source
  output lb_pkg::core_id_t   selected_core,
  output logic               desc_pop,
  input  lb_pkg::desc_t      desc_data,
  // Allocation results
  output lb_pkg::if_mask_t   result_valid,
  output lb_pkg::hash_t      result_hash,
  output lb_pkg::desc_t      result_desc,
  output logic               result_drop
);

  lb_alloc_if alloc_bus ();
  lb_cfg_if   cfg_bus ();

  lb_pkg::if_mask_t req_mask;
  lb_pkg::if_mask_t grant;
  logic             grant_valid;
  lb_pkg::if_id_t   grant_id;

  //////////////////////////////////////////////////
  // One queue per receive interface
  for (genvar g = 0; g < `LB_IF_COUNT; g++) begin : g_queue
    lb_hash_queue i_queue (
      .clk        (clk),
      .rst        (rst),
      .hash_valid (hash_valid[g]),
      .hash_in    (hash_in[g]),
      .line_count (line_count[g]),
      .port_idx   (lb_pkg::if_id_t'(g)),
      .alloc      (alloc_bus.queue),
      .cfg        (cfg_bus.queue)
    );
  end

  lb_rr_arbiter i_arbiter (
    .clk         (clk),
    .rst         (rst),
    .request     (req_mask),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_id    (grant_id)
  );

  lb_desc_alloc i_alloc (
    .clk           (clk),
    .rst           (rst),
    .grant         (grant),
    .grant_valid   (grant_valid),
    .grant_id      (grant_id),
    .selected_core (selected_core),
    .desc_pop      (desc_pop),
    .desc_data     (desc_data),
    .slot_valids   (slot_valids),
    .slots_busy    (slots_busy),
    .result_valid  (result_valid),
    .result_hash   (result_hash),
    .result_desc   (result_desc),
    .result_drop   (result_drop),
    .req_mask      (req_mask),
    .alloc         (alloc_bus.alloc),
    .cfg           (cfg_bus.alloc)
  );

  lb_host_regs i_regs (
    .clk               (clk),
    .rst               (rst),
    .host_cmd          (host_cmd),
    .host_cmd_for_ints (host_cmd_for_ints),
    .host_cmd_wr_data  (host_cmd_wr_data),
    .host_cmd_wr_en    (host_cmd_wr_en),
    .host_cmd_rd_data  (host_cmd_rd_data),
    .enabled_cores     (enabled_cores),
    .slots_flush       (slots_flush),
    .slot_counts       (slot_counts),
    .cfg               (cfg_bus.host)
  );

endmodule

/* logic/lb_hash_queue.sv */
// Per-interface hash FIFO with registered almost-full flag
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_hash_queue (
  input  logic               clk,
  input  logic               rst,
  input  logic               hash_valid,
  input  lb_pkg::hash_t      hash_in,
  input  lb_pkg::lines_t     line_count,
  input  lb_pkg::if_id_t     port_idx,
  lb_alloc_if.queue          alloc,
  lb_cfg_if.queue            cfg
);

  localparam int AW = $clog2(`LB_QUEUE_DEPTH);

  lb_pkg::hash_t mem [`LB_QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          pop_head;
  logic          almost_full_r;

  // Allocator pops only the head of a granted queue
  assign pop_head = alloc.pop[port_idx];

  //////////////////////////////////////////////////
  // Hash storage
  // Hashes arrive sparsely so the queue never overflows
  always_ff @(posedge clk) begin
    if (hash_valid) begin
      mem[wr_ptr] <= hash_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (hash_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_head) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({hash_valid, pop_head})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Receive side near full against the drop limit
  always_ff @(posedge clk) begin
    if (rst) begin
      almost_full_r <= 1'b0;
    end else begin
      almost_full_r <= (line_count >= cfg.drop_limit);
    end
  end

  // Own slot of the shared request bus
  assign alloc.req[port_idx]         = (count != '0);
  assign alloc.hash[port_idx]        = mem[rd_ptr];
  assign alloc.almost_full[port_idx] = almost_full_r;

endmodule

/* logic/lb_host_regs.sv */
// Host command decode, core and drop configuration, drop counters, readback
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_host_regs (
  input  logic               clk,
  input  logic               rst,
  input  lb_pkg::host_cmd_t  host_cmd,
  input  logic               host_cmd_for_ints,
  input  lb_pkg::word_t      host_cmd_wr_data,
  input  logic               host_cmd_wr_en,
  output lb_pkg::word_t      host_cmd_rd_data,
  output lb_pkg::core_mask_t enabled_cores,
  output lb_pkg::core_mask_t slots_flush,
  input  lb_pkg::slot_cnt_t  slot_counts [`LB_CORE_COUNT],
  lb_cfg_if.host             cfg
);

  logic [4:0]         addr;
  lb_pkg::core_id_t   rd_core;
  lb_pkg::if_id_t     rd_if;
  lb_pkg::core_mask_t wr_cores;
  lb_pkg::core_mask_t income_r;
  lb_pkg::lines_t     drop_limit_r;
  lb_pkg::word_t      drop_count [`LB_IF_COUNT];

  // Interface bit on top of the register field
  assign addr     = {host_cmd_for_ints, host_cmd[3:0]};
  assign rd_core  = host_cmd[4 +: `LB_CORE_W];
  assign rd_if    = host_cmd[4 +: `LB_IF_W];
  assign wr_cores = host_cmd_wr_data[`LB_CORE_COUNT-1:0];

  //////////////////////////////////////////////////
  // Configuration writes
  always_ff @(posedge clk) begin
    if (rst) begin
      enabled_cores <= '0;
      income_r      <= '0;
      slots_flush   <= '0;
      drop_limit_r  <= `LB_LIMIT_RESET;
    end else begin
      // Flush lasts one cycle
      slots_flush <= '0;
      if (host_cmd_wr_en) begin
        case (addr)
          `LB_REG_ENABLED: begin
            // Disabled core stops taking traffic too
            income_r      <= income_r & wr_cores;
            enabled_cores <= wr_cores;
          end
          `LB_REG_INCOME: income_r     <= wr_cores & enabled_cores;
          `LB_REG_FLUSH:  slots_flush  <= wr_cores;
          `LB_REG_LIMIT:  drop_limit_r <= host_cmd_wr_data[`LB_LINES_W-1:0];
          default:        ;
        endcase
      end
    end
  end

  assign cfg.income_cores = income_r;
  assign cfg.drop_limit   = drop_limit_r;

  // Drops seen per interface
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LB_IF_COUNT; i++) begin
        drop_count[i] <= '0;
      end
    end else if (cfg.drop_strobe) begin
      drop_count[cfg.drop_port] <= drop_count[cfg.drop_port] + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Readback, one cycle after the command
  always_ff @(posedge clk) begin
    case (addr)
      `LB_REG_ENABLED: host_cmd_rd_data <= lb_pkg::word_t'(enabled_cores);
      `LB_REG_INCOME:  host_cmd_rd_data <= lb_pkg::word_t'(income_r);
      `LB_REG_SLOTS:   host_cmd_rd_data <= lb_pkg::word_t'(slot_counts[rd_core]);
      `LB_REG_DROPS:   host_cmd_rd_data <= drop_count[rd_if];
      default:         host_cmd_rd_data <= `LB_RD_DEFAULT;
    endcase
  end

endmodule

/* logic/lb_pkg.sv */
// Load balancer vector types and arbiter state encoding
package lb_pkg;

`include "lb_defs.svh"

  // Flow hash from a receive interface
  typedef logic [`LB_HASH_W-1:0] hash_t;

  // Core numbering and masks
  typedef logic [`LB_CORE_W-1:0] core_id_t;
  typedef logic [`LB_CORE_COUNT-1:0] core_mask_t;

  // Interface numbering and masks
  typedef logic [`LB_IF_W-1:0] if_id_t;
  typedef logic [`LB_IF_COUNT-1:0] if_mask_t;

  // Descriptor is core id followed by slot tag
  typedef logic [`LB_CORE_W+`LB_TAG_W-1:0] desc_t;

  // Receive fill level and per-core slot count
  typedef logic [`LB_LINES_W-1:0] lines_t;
  typedef logic [`LB_SLOT_W-1:0] slot_cnt_t;

  // Host command, register in 3:0 and index from bit 4
  typedef logic [`LB_CMD_W-1:0] host_cmd_t;
  typedef logic [`LB_WORD_W-1:0] word_t;

  // Arbiter either has no winner yet or holds the last one
  typedef enum logic {
    ARB_IDLE,
    ARB_HOLD
  } arb_state_t;

endpackage

/* logic/lb_rr_arbiter.sv */
// Same-cycle round-robin arbiter with last winner memory
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_rr_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  lb_pkg::if_mask_t request,
  output lb_pkg::if_mask_t grant,
  output logic             grant_valid,
  output lb_pkg::if_id_t   grant_id
);

  localparam int N = `LB_IF_COUNT;

  lb_pkg::arb_state_t state;
  lb_pkg::if_id_t     last_id;

  // Search starts one past the last winner
  always_comb begin
    int base;
    int idx;
    base        = (state == lb_pkg::ARB_IDLE) ? N - 1 : int'(last_id);
    grant       = '0;
    grant_valid = 1'b0;
    grant_id    = '0;
    for (int off = 1; off <= N; off++) begin
      idx = (base + off) % N;
      // First requester in rotated order wins
      if (!grant_valid && request[idx]) begin
        grant[idx]  = 1'b1;
        grant_valid = 1'b1;
        grant_id    = lb_pkg::if_id_t'(idx);
      end
    end
  end

  // Every grant is taken, so always remember it
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= lb_pkg::ARB_IDLE;
      last_id <= '0;
    end else if (grant_valid) begin
      state   <= lb_pkg::ARB_HOLD;
      last_id <= grant_id;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the load balancer testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module lb_tb \
  --Mdir "$BUILD_DIR" -o lb_sim

./"$BUILD_DIR"/lb_sim | tee "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
else
  echo "Simulation did not pass, see $LOG"
  exit 1
fi
